// File: Bender.yml
package:
  name: dbg_uart

sources:
  - files:
      - rtl/dbg_uart_pkg.sv
      - rtl/dbg_mem_if.sv
      - rtl/uart_rx.sv
      - rtl/uart_tx.sv
      - rtl/dbg_mem.sv
      - rtl/dbg_cmd_engine.sv
      - rtl/dbg_uart_top.sv
  - target: test
    include_dirs:
      - dv
    files:
      - dv/tb_dbg_uart.sv

// File: dv/tb_uart_host.svh
`ifndef TB_UART_HOST_SVH
`define TB_UART_HOST_SVH

// Host side of the serial line with one bit per ClksPerBit clock cycles

// Byte model of the DUT memory indexed by address modulo the depth
byte_t ref_mem [MemDepth];

task automatic send_byte(input byte_t data);
  logic [9:0] frame;
  frame = {1'b1, data, 1'b0};
  @(posedge clk);
  #1;
  for (int i = 0; i < 10; i++) begin
    uart_rx_i = frame[i];
    repeat (ClksPerBit) @(posedge clk);
    #1;
  end
endtask

// LSB first
task automatic send_field(input field_t value);
  for (int i = 0; i < field_bytes_c; i++) begin
    send_byte(value[8*i +: 8]);
  end
endtask

// Exec carries no length field
task automatic send_command(input byte_t cmd, input field_t addr, input field_t len);
  send_byte(cmd);
  send_field(addr);
  if (cmd != cmd_exec_c) send_field(len);
endtask

// Samples each bit at its middle on the falling clock
task automatic receive_frame(output byte_t data);
  @(negedge uart_tx_o);
  repeat (ClksPerBit / 2) @(negedge clk);
  assert (uart_tx_o === 1'b0)
    else stop_run("Start bit of a reply frame is not low at its middle");
  for (int i = 0; i < 8; i++) begin
    repeat (ClksPerBit) @(negedge clk);
    data[i] = uart_tx_o;
  end
  repeat (ClksPerBit) @(negedge clk);
  assert (uart_tx_o === 1'b1)
    else stop_run("Stop bit of a reply frame is low");
endtask

task automatic expect_reply(input string name, input byte_t exp);
  byte_t act;
  while (rx_q.size() == 0) @(posedge clk);
  act = rx_q.pop_front();
  assert (act === exp)
    else report_mismatch(name, field_t'(exp), field_t'(act));
endtask

`endif

// File: dv/tb_dbg_uart.sv
module tb_dbg_uart
  import dbg_uart_pkg::*;
#(
  parameter int unsigned ClksPerBit = 16,
  parameter int unsigned MemDepth   = 256
) ();

  localparam int unsigned ClkPeriod = 8;
  localparam int unsigned BlockLen  = 16;

  // Challenges, two writes, two reads, exec, one unknown byte
  localparam int unsigned TotalBytes = 2 * 2 + 4 * (9 + BlockLen + 2) + 6 + 1;
  localparam longint unsigned WatchdogTime =
    longint'(TotalBytes) * 10 * ClksPerBit * ClkPeriod * 2;

  logic   clk;
  logic   reset_i;
  logic   uart_rx_i;
  logic   uart_tx_o;
  logic   exec_valid_o;
  field_t exec_addr_o;

  logic   idle_check;
  byte_t  rx_q [$];
  int     exec_count = 0;
  field_t exec_addr_seen;

  dbg_uart_top #(
    .ClksPerBit(ClksPerBit),
    .MemDepth  (MemDepth)
  ) dbg_uart_top_i (
    .clk         (clk),
    .reset_i     (reset_i),
    .uart_rx_i   (uart_rx_i),
    .uart_tx_o   (uart_tx_o),
    .exec_valid_o(exec_valid_o),
    .exec_addr_o (exec_addr_o)
  );

  always #(ClkPeriod / 2) clk = ~clk;

  task automatic stop_run(input string line);
    $display("%s", line);
    $display("TEST FAILED");
    $fatal(1, "Run stopped at the first error");
  endtask

  task automatic report_mismatch(input string name, input field_t exp, input field_t act);
    stop_run($sformatf("[ERROR] %0t %s expected %0h actual %0h", $time, name, exp, act));
  endtask

  `include "tb_uart_host.svh"

  task automatic expect_silence(input int frames);
    repeat (frames * 10 * ClksPerBit) @(posedge clk);
    assert (rx_q.size() == 0)
      else stop_run("Unexpected reply frame from the DUT");
  endtask

  task automatic write_block(input field_t addr, input int len);
    byte_t data;
    send_command(cmd_write_c, addr, field_t'(len));
    for (int i = 0; i < len; i++) begin
      data = byte_t'($urandom);
      ref_mem[(addr + field_t'(i)) % MemDepth] = data;
      send_byte(data);
    end
    expect_reply("uart_tx_o write ACK", ack_c);
    expect_reply("uart_tx_o write EOT", eot_c);
  endtask

  task automatic read_block(input field_t addr, input int len);
    send_command(cmd_read_c, addr, field_t'(len));
    expect_reply("uart_tx_o read ACK", ack_c);
    for (int i = 0; i < len; i++) begin
      expect_reply($sformatf("uart_tx_o read byte %0d", i),
                   ref_mem[(addr + field_t'(i)) % MemDepth]);
    end
    expect_reply("uart_tx_o read EOT", eot_c);
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Monitors and checks
  ////////////////////////////////////////////////////////////////////////////

  // Collects every reply frame
  initial begin : reply_collector
    byte_t data;
    wait (reset_i === 1'b0);
    forever begin
      receive_frame(data);
      rx_q.push_back(data);
    end
  end

  always @(negedge clk) begin
    if (exec_valid_o === 1'b1) begin
      exec_count     = exec_count + 1;
      exec_addr_seen = exec_addr_o;
    end
  end

  idle_outputs_a: assert property (@(posedge clk) idle_check |-> (uart_tx_o && !exec_valid_o))
    else stop_run($sformatf("[ERROR] %0t uart_tx_o/exec_valid_o expected 1/0 actual %b/%b",
                            $time, $sampled(uart_tx_o), $sampled(exec_valid_o)));

  initial begin : watchdog
    #(WatchdogTime);
    stop_run("Timeout, the test sequence did not complete in time");
  end

  ////////////////////////////////////////////////////////////////////////////
  // Test sequence
  ////////////////////////////////////////////////////////////////////////////

  initial begin : test_sequence
    field_t addr;
    void'($urandom(32'he6ec));
    clk        = 1'b0;
    reset_i    = 1'b1;
    uart_rx_i  = 1'b1;
    idle_check = 1'b0;
    repeat (4) @(posedge clk);
    #1;
    reset_i    = 1'b0;
    idle_check = 1'b1;
    // Quiet line before any command
    repeat (4 * ClksPerBit) @(posedge clk);
    #1;
    idle_check = 1'b0;

    send_byte(ack_c);
    expect_reply("uart_tx_o challenge ACK", ack_c);
    expect_silence(2);

    addr = field_t'($urandom);
    write_block(addr, BlockLen);
    read_block(addr, BlockLen);

    // Same bytes reached through the wrapped address
    write_block(addr + field_t'(MemDepth), BlockLen);
    read_block(addr, BlockLen);

    addr = field_t'($urandom);
    send_command(cmd_exec_c, addr, '0);
    expect_reply("uart_tx_o exec ACK", ack_c);
    expect_silence(2);
    assert (exec_count == 1)
      else stop_run($sformatf("exec_valid_o pulsed %0d times instead of once", exec_count));
    assert (exec_addr_seen === addr)
      else report_mismatch("exec_addr_o", addr, exec_addr_seen);

    // Byte outside the command set gets no reply
    send_byte(8'h5a);
    expect_silence(3);
    send_byte(ack_c);
    expect_reply("uart_tx_o challenge ACK after unknown byte", ack_c);
    expect_silence(2);
    assert (exec_count == 1)
      else stop_run("exec_valid_o pulsed again after the exec command");

    $display("TEST PASSED");
    $finish;
  end

endmodule

// File: filelist.f
+incdir+dv
rtl/dbg_uart_pkg.sv
rtl/dbg_mem_if.sv
rtl/uart_rx.sv
rtl/uart_tx.sv
rtl/dbg_mem.sv
rtl/dbg_cmd_engine.sv
rtl/dbg_uart_top.sv
dv/tb_dbg_uart.sv

// File: rtl/dbg_cmd_engine.sv
module dbg_cmd_engine
  import dbg_uart_pkg::*;
#(
  parameter int unsigned MemDepth = 256
) (
  input  logic    clk,
  input  logic    reset_i,
  input  logic    rx_valid_i,
  input  byte_t   rx_data_i,
  output logic    tx_start_o,
  output byte_t   tx_data_o,
  input  logic    tx_busy_i,
  dbg_mem_if.ctrl mem,
  output logic    exec_valid_o,
  output field_t  exec_addr_o
);

  localparam int unsigned AddrWidth     = $clog2(MemDepth);
  localparam int unsigned FieldCntWidth = $clog2(field_bytes_c);

  typedef enum logic [2:0] {
    st_idle,
    st_addr,
    st_len,
    st_ack,
    st_wr,
    st_rd_req,
    st_rd_send,
    st_eot
  } state_e;

  state_e                   state_q;
  byte_t                    cmd_q;
  logic [FieldCntWidth-1:0] field_cnt_q;
  field_t                   addr_q;
  field_t                   len_q;
  logic                     wr_en_q;
  byte_t                    wdata_q;
  logic                     last_field_byte;
  logic                     last_data_byte;

  assign last_field_byte = (field_cnt_q == FieldCntWidth'(field_bytes_c - 1));
  assign last_data_byte  = (len_q == field_t'(1));

  ////////////////////////////////////////////////////////////////////////////
  // Protocol FSM
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (reset_i) begin
      state_q     <= st_idle;
      cmd_q       <= '0;
      field_cnt_q <= '0;
      addr_q      <= '0;
      len_q       <= '0;
      wr_en_q     <= 1'b0;
    end else begin
      wr_en_q <= 1'b0;
      // Advance after each memory write
      if (wr_en_q) addr_q <= addr_q + 1'b1;
      unique case (state_q)
        st_idle: begin
          if (rx_valid_i) begin
            cmd_q       <= rx_data_i;
            field_cnt_q <= '0;
            // Unknown bytes are dropped here
            if (rx_data_i == ack_c) begin
              state_q <= st_ack;
            end else if (rx_data_i inside {cmd_read_c, cmd_write_c, cmd_exec_c}) begin
              state_q <= st_addr;
            end
          end
        end
        st_addr: begin
          if (rx_valid_i) begin
            addr_q      <= {rx_data_i, addr_q[$bits(field_t)-1:8]};
            field_cnt_q <= field_cnt_q + 1'b1;
            if (last_field_byte) begin
              field_cnt_q <= '0;
              state_q     <= (cmd_q == cmd_exec_c) ? st_ack : st_len;
            end
          end
        end
        st_len: begin
          if (rx_valid_i) begin
            len_q       <= {rx_data_i, len_q[$bits(field_t)-1:8]};
            field_cnt_q <= field_cnt_q + 1'b1;
            if (last_field_byte) begin
              field_cnt_q <= '0;
              state_q     <= st_ack;
            end
          end
        end
        st_ack: begin
          if (!tx_busy_i) begin
            if (cmd_q == cmd_read_c) begin
              state_q <= (len_q == '0) ? st_eot : st_rd_req;
            end else if (cmd_q == cmd_write_c) begin
              state_q <= (len_q == '0) ? st_eot : st_wr;
            end else begin
              // Challenge or exec
              state_q <= st_idle;
            end
          end
        end
        st_wr: begin
          if (rx_valid_i) begin
            wr_en_q <= 1'b1;
            len_q   <= len_q - 1'b1;
            if (last_data_byte) state_q <= st_eot;
          end
        end
        st_rd_req: begin
          state_q <= st_rd_send;
        end
        st_rd_send: begin
          if (!tx_busy_i) begin
            addr_q  <= addr_q + 1'b1;
            len_q   <= len_q - 1'b1;
            state_q <= last_data_byte ? st_eot : st_rd_req;
          end
        end
        default: begin
          if (!tx_busy_i) state_q <= st_idle;
        end
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (state_q == st_wr && rx_valid_i) wdata_q <= rx_data_i;
  end

  ////////////////////////////////////////////////////////////////////////////
  // Memory port and replies
  ////////////////////////////////////////////////////////////////////////////

  // Index wraps modulo the memory depth
  assign mem.addr  = addr_q[AddrWidth-1:0];
  assign mem.rd_en = (state_q == st_rd_req);
  assign mem.wr_en = wr_en_q;
  assign mem.wdata = wdata_q;

  assign tx_start_o = !tx_busy_i && (state_q inside {st_ack, st_rd_send, st_eot});

  always_comb begin
    unique case (state_q)
      st_rd_send: tx_data_o = mem.rdata;
      st_eot:     tx_data_o = eot_c;
      default:    tx_data_o = ack_c;
    endcase
  end

  // Pulse together with the exec ACK
  assign exec_valid_o = (state_q == st_ack) && !tx_busy_i && (cmd_q == cmd_exec_c);
  assign exec_addr_o  = addr_q;

endmodule

// File: rtl/dbg_mem.sv
module dbg_mem
  import dbg_uart_pkg::*;
#(
  parameter int unsigned MemDepth = 256
) (
  input logic      clk,
  dbg_mem_if.mem   mem
);

  localparam int unsigned AddrWidth = $clog2(MemDepth);

  // Power-of-two depth, so the index covers the array exactly
  byte_t ram_q [2**AddrWidth];

  always_ff @(posedge clk) begin
    if (mem.wr_en) begin
      ram_q[mem.addr] <= mem.wdata;
    end
  end

  // Registered read that keeps rdata until the next read strobe
  always_ff @(posedge clk) begin
    if (mem.rd_en) begin
      mem.rdata <= ram_q[mem.addr];
    end
  end

endmodule

// File: rtl/dbg_mem_if.sv
interface dbg_mem_if
  import dbg_uart_pkg::*;
#(
  parameter int unsigned MemDepth = 256
);

  localparam int unsigned AddrWidth = $clog2(MemDepth);

  logic                 rd_en;
  logic                 wr_en;
  logic [AddrWidth-1:0] addr;
  byte_t                wdata;
  // Valid one cycle after rd_en
  byte_t                rdata;

  modport ctrl (output rd_en, output wr_en, output addr, output wdata, input rdata);

  modport mem (input rd_en, input wr_en, input addr, input wdata, output rdata);

endinterface

// File: rtl/dbg_uart_pkg.sv
package dbg_uart_pkg;

  // Basic data unit on the serial line and in memory
  typedef logic [7:0] byte_t;

  ////////////////////////////////////////////////////////////////////////////
  // Protocol byte codes
  ////////////////////////////////////////////////////////////////////////////

  // Commands from the host
  localparam byte_t cmd_read_c  = 8'h11;
  localparam byte_t cmd_write_c = 8'h12;
  localparam byte_t cmd_exec_c  = 8'h13;

  // Replies to the host
  // ACK also serves as the challenge byte
  localparam byte_t ack_c = 8'h06;
  localparam byte_t eot_c = 8'h04;

  ////////////////////////////////////////////////////////////////////////////
  // Command fields
  ////////////////////////////////////////////////////////////////////////////

  // Address and length are sent LSB first
  localparam int unsigned field_bytes_c = 4;

  typedef logic [8*field_bytes_c-1:0] field_t;

endpackage

// File: rtl/dbg_uart_top.sv
module dbg_uart_top
  import dbg_uart_pkg::*;
#(
  parameter int unsigned ClksPerBit = 16,
  parameter int unsigned MemDepth   = 256
) (
  input  logic   clk,
  input  logic   reset_i,
  input  logic   uart_rx_i,
  output logic   uart_tx_o,
  output logic   exec_valid_o,
  output field_t exec_addr_o
);

  logic  rx_valid;
  byte_t rx_data;
  logic  tx_start;
  byte_t tx_data;
  logic  tx_busy;

  dbg_mem_if #(.MemDepth(MemDepth)) mem_bus ();

  uart_rx #(.ClksPerBit(ClksPerBit)) uart_receiver_i (
    .clk       (clk),
    .reset_i   (reset_i),
    .rx_i      (uart_rx_i),
    .rx_valid_o(rx_valid),
    .rx_data_o (rx_data)
  );

  uart_tx #(.ClksPerBit(ClksPerBit)) uart_transmitter_i (
    .clk       (clk),
    .reset_i   (reset_i),
    .tx_start_i(tx_start),
    .tx_data_i (tx_data),
    .tx_busy_o (tx_busy),
    .tx_o      (uart_tx_o)
  );

  dbg_cmd_engine #(.MemDepth(MemDepth)) dbg_cmd_engine_i (
    .clk         (clk),
    .reset_i     (reset_i),
    .rx_valid_i  (rx_valid),
    .rx_data_i   (rx_data),
    .tx_start_o  (tx_start),
    .tx_data_o   (tx_data),
    .tx_busy_i   (tx_busy),
    .mem         (mem_bus.ctrl),
    .exec_valid_o(exec_valid_o),
    .exec_addr_o (exec_addr_o)
  );

  dbg_mem #(.MemDepth(MemDepth)) dbg_mem_i (
    .clk(clk),
    .mem(mem_bus.mem)
  );

endmodule

// File: rtl/uart_rx.sv
module uart_rx
  import dbg_uart_pkg::*;
#(
  parameter int unsigned ClksPerBit = 16
) (
  input  logic  clk,
  input  logic  reset_i,
  input  logic  rx_i,
  output logic  rx_valid_o,
  output byte_t rx_data_o
);

  localparam int unsigned CntWidth = $clog2(ClksPerBit);

  typedef enum logic [1:0] {rx_idle, rx_start, rx_bits, rx_stop} rx_state_e;

  rx_state_e           state_q;
  logic [1:0]          sync_q;
  logic                rx_prev_q;
  logic [CntWidth-1:0] clk_cnt_q;
  logic [2:0]          bit_cnt_q;
  byte_t               shift_q;
  logic                rx_bit;
  logic                bit_done;

  assign rx_bit   = sync_q[1];
  assign bit_done = (clk_cnt_q == CntWidth'(ClksPerBit - 1));

  // Line idles high, so sync and edge flops reset to one
  always_ff @(posedge clk) begin
    if (reset_i) begin
      sync_q    <= 2'b11;
      rx_prev_q <= 1'b1;
    end else begin
      sync_q    <= {sync_q[0], rx_i};
      rx_prev_q <= rx_bit;
    end
  end

  always_ff @(posedge clk) begin
    if (reset_i) begin
      state_q    <= rx_idle;
      clk_cnt_q  <= '0;
      bit_cnt_q  <= '0;
      rx_valid_o <= 1'b0;
    end else begin
      rx_valid_o <= 1'b0;
      clk_cnt_q  <= clk_cnt_q + 1'b1;
      unique case (state_q)
        rx_idle: begin
          clk_cnt_q <= '0;
          // Falling edge starts a frame
          if (rx_prev_q && !rx_bit) state_q <= rx_start;
        end
        rx_start: begin
          if (clk_cnt_q == CntWidth'(ClksPerBit / 2 - 1)) begin
            clk_cnt_q <= '0;
            bit_cnt_q <= '0;
            // Glitch, not a start bit
            state_q   <= rx_bit ? rx_idle : rx_bits;
          end
        end
        rx_bits: begin
          if (bit_done) begin
            clk_cnt_q <= '0;
            bit_cnt_q <= bit_cnt_q + 1'b1;
            if (bit_cnt_q == 3'd7) state_q <= rx_stop;
          end
        end
        default: begin
          // Middle of the stop bit
          if (bit_done) begin
            state_q    <= rx_idle;
            rx_valid_o <= rx_bit;
          end
        end
      endcase
    end
  end

  // LSB arrives first
  always_ff @(posedge clk) begin
    if (state_q == rx_bits && bit_done) shift_q <= {rx_bit, shift_q[7:1]};
  end

  assign rx_data_o = shift_q;

endmodule

// File: rtl/uart_tx.sv
module uart_tx
  import dbg_uart_pkg::*;
#(
  parameter int unsigned ClksPerBit = 16
) (
  input  logic  clk,
  input  logic  reset_i,
  input  logic  tx_start_i,
  input  byte_t tx_data_i,
  output logic  tx_busy_o,
  output logic  tx_o
);

  localparam int unsigned CntWidth = $clog2(ClksPerBit);

  logic                busy_q;
  logic [9:0]          frame_q;
  logic [CntWidth-1:0] clk_cnt_q;
  logic [3:0]          bit_cnt_q;
  logic                load;
  logic                bit_end;

  assign load    = tx_start_i && !busy_q;
  assign bit_end = busy_q && (clk_cnt_q == CntWidth'(ClksPerBit - 1));

  always_ff @(posedge clk) begin
    if (reset_i) begin
      busy_q    <= 1'b0;
      clk_cnt_q <= '0;
      bit_cnt_q <= '0;
    end else if (load) begin
      busy_q    <= 1'b1;
      clk_cnt_q <= '0;
      bit_cnt_q <= '0;
    end else if (bit_end) begin
      clk_cnt_q <= '0;
      // Busy drops at the end of the stop bit
      if (bit_cnt_q == 4'd9) busy_q <= 1'b0;
      else bit_cnt_q <= bit_cnt_q + 1'b1;
    end else if (busy_q) begin
      clk_cnt_q <= clk_cnt_q + 1'b1;
    end
  end

  // Stop, data, start from MSB to LSB
  always_ff @(posedge clk) begin
    if (load) frame_q <= {1'b1, tx_data_i, 1'b0};
    else if (bit_end) frame_q <= {1'b1, frame_q[9:1]};
  end

  assign tx_busy_o = busy_q;
  assign tx_o      = busy_q ? frame_q[0] : 1'b1;

endmodule
